//--- priv_csr.f
+incdir+hw
hw/priv_csr_pkg.sv
hw/trap_cause_unit.sv
hw/trap_bank.sv
hw/priv_status.sv
hw/csr_read_mux.sv
hw/priv_csr_top.sv
tb/priv_csr_tb.sv

//--- tb/priv_csr_tb.sv
// testbench for the privileged CSR and trap block
// table of CSR, trap and return steps with precomputed expected values
`timescale 1ns/1ps
`include "priv_csr_defs.svh"

module priv_csr_tb;
    import priv_csr_pkg::*;

    localparam logic [2:0] K_WR  = 3'd0;
    localparam logic [2:0] K_RD  = 3'd1;
    localparam logic [2:0] K_EXC = 3'd2;
    localparam logic [2:0] K_IRQ = 3'd3;
    localparam logic [2:0] K_RET = 3'd4;

    // exception sources, and irq bits {m_ext, m_sw, m_tmr, s_ext, s_sw, s_tmr}
    localparam logic [7:0] EX_ILGL  = 8'd1;
    localparam logic [7:0] EX_ECALL = 8'd4;
    localparam logic [7:0] IRQ_ME   = 8'h20;
    localparam logic [7:0] IRQ_MT   = 8'h08;

    localparam logic [11:0] A_MTVEC    = {4'b0011, `PRIV_ADDR_TVEC_LO};
    localparam logic [11:0] A_MSCRATCH = {4'b0011, `PRIV_ADDR_SCRATCH_LO};
    localparam logic [11:0] A_MEPC     = {4'b0011, `PRIV_ADDR_EPC_LO};
    localparam logic [11:0] A_MCAUSE   = {4'b0011, `PRIV_ADDR_CAUSE_LO};
    localparam logic [11:0] A_MTVAL    = {4'b0011, `PRIV_ADDR_TVAL_LO};
    localparam logic [11:0] A_STVEC    = {4'b0001, `PRIV_ADDR_TVEC_LO};
    localparam logic [11:0] A_SSCRATCH = {4'b0001, `PRIV_ADDR_SCRATCH_LO};
    localparam logic [11:0] A_SEPC     = {4'b0001, `PRIV_ADDR_EPC_LO};
    localparam logic [11:0] A_SCAUSE   = {4'b0001, `PRIV_ADDR_CAUSE_LO};

    typedef struct packed {
        logic [2:0]  kind;
        logic [11:0] addr;
        logic [7:0]  src;
        logic [31:0] data;
        logic [31:0] aux;
        logic [31:0] exp_val;
        logic [31:0] exp_cause;
        logic [2:0]  exp_flags;
        logic [1:0]  exp_mode;
    } step_t;

    logic clk_i, resetb_i, stage_en_i, access_i, wr_i, ex_valid_i;
    logic [11:0] addr_i, wr_addr_i;
    logic [31:0] wr_data_i, excp_pc_i, excp_ins_i;
    logic irq_m_ext_i, irq_m_sw_i, irq_m_tmr_i, irq_s_ext_i, irq_s_sw_i, irq_s_tmr_i;
    logic excp_ferr_i, excp_ilgl_i, excp_mala_i, excp_masa_i, excp_ecall_i;
    logic trap_rtn_i;
    logic [1:0] trap_rtn_mode_i;
    logic bad_csr_addr_o, readonly_csr_o, priv_too_low_o, interrupt_o, jump_to_trap_o;
    logic [31:0] rd_data_o, trap_entry_addr_o, trap_rtn_addr_o, trap_cause_o;
    priv_mode_e mode_o;

    step_t       steps[$];
    int unsigned cycles;
    int unsigned cycle_limit;
    int unsigned step_errs;
    int unsigned pass_cnt;
    int unsigned fail_cnt;
    logic [31:0] r0, r1, r2, r3;
    logic [31:0] ill_ins;

    priv_csr_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // abort if the table stalls
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run aborted, cycle limit of %0d reached before the table finished",
                     cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            step_errs++;
        end
    endtask

    task automatic add_step(input logic [2:0] kind, input logic [11:0] addr,
                            input logic [7:0] src, input logic [31:0] data,
                            input logic [31:0] aux, input logic [31:0] exp_val,
                            input logic [31:0] exp_cause, input logic [2:0] exp_flags,
                            input logic [1:0] exp_mode);
        steps.push_back({kind, addr, src, data, aux, exp_val, exp_cause, exp_flags, exp_mode});
    endtask

    task automatic idle_inputs();
        access_i = 1'b0;
        addr_i = '0;
        wr_i = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        ex_valid_i = 1'b0;
        {irq_m_ext_i, irq_m_sw_i, irq_m_tmr_i, irq_s_ext_i, irq_s_sw_i, irq_s_tmr_i} = '0;
        {excp_ferr_i, excp_ilgl_i, excp_mala_i, excp_masa_i, excp_ecall_i} = '0;
        excp_pc_i = '0;
        excp_ins_i = '0;
        trap_rtn_i = 1'b0;
        trap_rtn_mode_i = '0;
    endtask

    // ----------------------------------------
    // one table step, driven on the falling edge
    // ----------------------------------------
    task automatic run_step(input step_t s);
        @(negedge clk_i);
        case (s.kind)
            K_WR: begin
                wr_i = 1'b1;
                wr_addr_i = s.addr;
                wr_data_i = s.data;
            end
            K_RD: begin
                access_i = 1'b1;
                addr_i = s.addr;
            end
            K_EXC: begin
                ex_valid_i = 1'b1;
                excp_pc_i = s.data;
                excp_ins_i = s.aux;
                {excp_ecall_i, excp_masa_i, excp_mala_i, excp_ilgl_i, excp_ferr_i} =
                    5'b1 << s.src;
            end
            K_IRQ: begin
                ex_valid_i = 1'b1;
                excp_pc_i = s.data;
                {irq_m_ext_i, irq_m_sw_i, irq_m_tmr_i, irq_s_ext_i, irq_s_sw_i, irq_s_tmr_i} =
                    s.src[5:0];
            end
            default: begin
                trap_rtn_i = 1'b1;
                trap_rtn_mode_i = s.src[1:0];
            end
        endcase
        // combinational outputs, mid low phase
        #1;
        check("interrupt_o", interrupt_o, (s.kind == K_IRQ) ? 32'd1 : 32'd0);
        if (s.kind == K_EXC || s.kind == K_IRQ) begin
            check("jump_to_trap_o", jump_to_trap_o, 32'd1);
            check("trap_cause_o", trap_cause_o, s.exp_cause);
            check("trap_entry_addr_o", trap_entry_addr_o, s.exp_val);
        end else begin
            check("jump_to_trap_o", jump_to_trap_o, 32'd0);
        end
        if (s.kind == K_RET)
            check("trap_rtn_addr_o", trap_rtn_addr_o, s.exp_val);
        @(negedge clk_i);
        idle_inputs();
        if (s.kind == K_RD) begin
            check("rd_data_o", rd_data_o, s.exp_val);
            check("bad_csr_addr_o", bad_csr_addr_o, s.exp_flags[2]);
            check("readonly_csr_o", readonly_csr_o, s.exp_flags[1]);
            check("priv_too_low_o", priv_too_low_o, s.exp_flags[0]);
        end
        check("mode_o", mode_o, s.exp_mode);
    endtask

    initial begin
        cycles = 0;
        cycle_limit = 50;
        pass_cnt = 0;
        fail_cnt = 0;
        r0 = $urandom(40002);
        r1 = $urandom();
        r2 = $urandom();
        r3 = $urandom();
        ill_ins = 32'h1234_5073;

        // reset state and scratch/epc read back
        add_step(K_RD, `PRIV_ADDR_MHARTID, 0, 0, 0, `PRIV_HART_ID, 0, 3'b010, MODE_M);
        add_step(K_RD, A_MTVEC, 0, 0, 0, `PRIV_RESET_VECTOR, 0, 3'b000, MODE_M);
        add_step(K_WR, A_MSCRATCH, 0, r0, 0, 0, 0, 0, MODE_M);
        add_step(K_WR, A_SSCRATCH, 0, r1, 0, 0, 0, 0, MODE_M);
        add_step(K_WR, A_MEPC, 0, r2, 0, 0, 0, 0, MODE_M);
        add_step(K_WR, A_SEPC, 0, r3, 0, 0, 0, 0, MODE_M);
        add_step(K_RD, A_MSCRATCH, 0, 0, 0, r0, 0, 3'b000, MODE_M);
        add_step(K_RD, A_SSCRATCH, 0, 0, 0, r1, 0, 3'b000, MODE_M);
        add_step(K_RD, A_MEPC, 0, 0, 0, r2 & ~32'h3, 0, 3'b000, MODE_M);
        add_step(K_RD, A_SEPC, 0, 0, 0, r3 & ~32'h3, 0, 3'b000, MODE_M);
        add_step(K_RD, 12'h3FF, 0, 0, 0, 0, 0, 3'b100, MODE_M);
        // ecall from M
        add_step(K_EXC, 0, EX_ECALL, 32'h2000, 0, 32'h100, 32'd11, 0, MODE_M);
        add_step(K_RD, A_MEPC, 0, 0, 0, 32'h2000, 0, 3'b000, MODE_M);
        add_step(K_RD, A_MCAUSE, 0, 0, 0, 32'd11, 0, 3'b000, MODE_M);
        // mret to U, then delegated ecall into S
        add_step(K_WR, `PRIV_ADDR_MEDELEG, 0, 32'h100, 0, 0, 0, 0, MODE_M);
        add_step(K_WR, A_STVEC, 0, 32'h3000, 0, 0, 0, 0, MODE_M);
        add_step(K_WR, `PRIV_ADDR_MSTATUS, 0, 32'h0, 0, 0, 0, 0, MODE_M);
        add_step(K_RET, 0, MODE_M, 0, 0, 32'h2000, 0, 0, MODE_U);
        add_step(K_RD, `PRIV_ADDR_MSTATUS, 0, 0, 0, 32'h80, 0, 3'b001, MODE_U);
        add_step(K_EXC, 0, EX_ECALL, 32'h2400, 0, 32'h3000, 32'd8, 0, MODE_S);
        add_step(K_RD, A_SEPC, 0, 0, 0, 32'h2400, 0, 3'b000, MODE_S);
        add_step(K_RD, A_SCAUSE, 0, 0, 0, 32'd8, 0, 3'b000, MODE_S);
        // vectored machine interrupts
        add_step(K_WR, A_MTVEC, 0, 32'h4001, 0, 0, 0, 0, MODE_S);
        add_step(K_WR, `PRIV_ADDR_MIE, 0, 32'h880, 0, 0, 0, 0, MODE_S);
        add_step(K_WR, `PRIV_ADDR_MSTATUS, 0, 32'h8, 0, 0, 0, 0, MODE_S);
        add_step(K_IRQ, 0, IRQ_ME | IRQ_MT, 32'h5000, 0, 32'h4000 + 4 * 11, 32'h8000_000B,
                 0, MODE_M);
        add_step(K_RD, A_MCAUSE, 0, 0, 0, 32'h8000_000B, 0, 3'b000, MODE_M);
        add_step(K_WR, `PRIV_ADDR_MSTATUS, 0, 32'h8, 0, 0, 0, 0, MODE_M);
        add_step(K_IRQ, 0, IRQ_MT, 32'h5100, 0, 32'h4000 + 4 * 7, 32'h8000_0007, 0, MODE_M);
        add_step(K_RD, A_MEPC, 0, 0, 0, 32'h5100, 0, 3'b000, MODE_M);
        // illegal instruction, then mret to a rewritten mepc
        add_step(K_EXC, 0, EX_ILGL, 32'h6000, ill_ins, 32'h4000, 32'd2, 0, MODE_M);
        add_step(K_RD, A_MTVAL, 0, 0, 0, ill_ins, 0, 3'b000, MODE_M);
        add_step(K_RD, A_MEPC, 0, 0, 0, 32'h6000, 0, 3'b000, MODE_M);
        add_step(K_WR, A_MEPC, 0, 32'h7006, 0, 0, 0, 0, MODE_M);
        add_step(K_RET, 0, MODE_M, 0, 0, 32'h7004, 0, 0, MODE_M);
        add_step(K_RD, `PRIV_ADDR_MSTATUS, 0, 0, 0, 32'h80, 0, 3'b000, MODE_M);

        cycle_limit = 20 * steps.size() + 50;

        idle_inputs();
        stage_en_i = 1'b0;
        resetb_i = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        resetb_i = 1'b1;
        stage_en_i = 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            step_errs = 0;
            run_step(steps[i]);
            if (step_errs == 0) begin
                pass_cnt++;
                $display("step %0d kind %0d addr %h: ok", i, steps[i].kind, steps[i].addr);
            end else begin
                fail_cnt++;
                $display("step %0d kind %0d addr %h: %0d mismatches", i, steps[i].kind,
                         steps[i].addr, step_errs);
            end
        end

        $display("steps run %0d, passed %0d, failed %0d", steps.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- hw/priv_csr_top.sv
// privileged CSR and trap block, top level
// joins cause unit, status registers, read mux and the per-level trap banks
`timescale 1ns/1ps
`include "priv_csr_defs.svh"

module priv_csr_top (
    input  logic                     clk_i,
    input  logic                     resetb_i,
    input  logic                     stage_en_i,
    input  logic                     access_i,
    input  logic [11:0]              addr_i,
    output logic                     bad_csr_addr_o,
    output logic                     readonly_csr_o,
    output logic                     priv_too_low_o,
    output logic [`PRIV_XLEN-1:0]    rd_data_o,
    input  logic                     wr_i,
    input  logic [11:0]              wr_addr_i,
    input  logic [`PRIV_XLEN-1:0]    wr_data_i,
    input  logic                     ex_valid_i,
    input  logic                     irq_m_ext_i,
    input  logic                     irq_m_sw_i,
    input  logic                     irq_m_tmr_i,
    input  logic                     irq_s_ext_i,
    input  logic                     irq_s_sw_i,
    input  logic                     irq_s_tmr_i,
    input  logic                     excp_ferr_i,
    input  logic                     excp_ilgl_i,
    input  logic                     excp_mala_i,
    input  logic                     excp_masa_i,
    input  logic                     excp_ecall_i,
    input  logic [`PRIV_XLEN-1:0]    excp_pc_i,
    input  logic [`PRIV_XLEN-1:0]    excp_ins_i,
    output logic                     interrupt_o,
    output logic                     jump_to_trap_o,
    output logic [`PRIV_XLEN-1:0]    trap_entry_addr_o,
    input  logic                     trap_rtn_i,
    input  logic [1:0]               trap_rtn_mode_i,
    output logic [`PRIV_XLEN-1:0]    trap_rtn_addr_o,
    output priv_csr_pkg::priv_mode_e mode_o,
    output logic [`PRIV_XLEN-1:0]    trap_cause_o
);
    import priv_csr_pkg::*;

    csr_wr_t      csr_wr;
    trap_info_t   trap;
    status_view_t status;
    bank_view_t   banks [`PRIV_NUM_BANKS];

    // a return in the same cycle wins over the write
    assign csr_wr.en   = wr_i & ~trap_rtn_i;
    assign csr_wr.addr = wr_addr_i;
    assign csr_wr.data = wr_data_i;

    assign jump_to_trap_o = trap.take;
    assign trap_cause_o   = trap.cause;

    trap_cause_unit u_cause (
        .status_i     (status),
        .ex_valid_i   (ex_valid_i),
        .irq_m_ext_i  (irq_m_ext_i),
        .irq_m_sw_i   (irq_m_sw_i),
        .irq_m_tmr_i  (irq_m_tmr_i),
        .irq_s_ext_i  (irq_s_ext_i),
        .irq_s_sw_i   (irq_s_sw_i),
        .irq_s_tmr_i  (irq_s_tmr_i),
        .excp_ferr_i  (excp_ferr_i),
        .excp_ilgl_i  (excp_ilgl_i),
        .excp_mala_i  (excp_mala_i),
        .excp_masa_i  (excp_masa_i),
        .excp_ecall_i (excp_ecall_i),
        .excp_pc_i    (excp_pc_i),
        .excp_ins_i   (excp_ins_i),
        .trap_o       (trap),
        .interrupt_o  (interrupt_o)
    );

    priv_status u_status (
        .clk_i           (clk_i),
        .resetb_i        (resetb_i),
        .stage_en_i      (stage_en_i),
        .wr_i            (csr_wr),
        .trap_i          (trap),
        .trap_rtn_i      (trap_rtn_i),
        .trap_rtn_mode_i (trap_rtn_mode_i),
        .status_o        (status),
        .mode_o          (mode_o)
    );

    // bank 0 serves M, bank 1 serves S
    for (genvar i = 0; i < `PRIV_NUM_BANKS; i++) begin : g_bank
        trap_bank #(
            .LEVEL ((i == `PRIV_BANK_M) ? MODE_M : MODE_S)
        ) u_bank (
            .clk_i      (clk_i),
            .resetb_i   (resetb_i),
            .stage_en_i (stage_en_i),
            .wr_i       (csr_wr),
            .trap_i     (trap),
            .view_o     (banks[i])
        );
    end

    csr_read_mux u_rd_mux (
        .clk_i             (clk_i),
        .resetb_i          (resetb_i),
        .stage_en_i        (stage_en_i),
        .access_i          (access_i),
        .addr_i            (addr_i),
        .status_i          (status),
        .banks_i           (banks),
        .trap_i            (trap),
        .trap_rtn_mode_i   (trap_rtn_mode_i),
        .rd_data_o         (rd_data_o),
        .bad_csr_addr_o    (bad_csr_addr_o),
        .readonly_csr_o    (readonly_csr_o),
        .priv_too_low_o    (priv_too_low_o),
        .trap_entry_addr_o (trap_entry_addr_o),
        .trap_rtn_addr_o   (trap_rtn_addr_o)
    );

endmodule

//--- hw/csr_read_mux.sv
// CSR read mux and access checks
// registered read data and flags, trap entry and return address select
`timescale 1ns/1ps
`include "priv_csr_defs.svh"

module csr_read_mux (
    input  logic                       clk_i,
    input  logic                       resetb_i,
    input  logic                       stage_en_i,
    input  logic                       access_i,
    input  logic [11:0]                addr_i,
    input  priv_csr_pkg::status_view_t status_i,
    input  priv_csr_pkg::bank_view_t   banks_i [`PRIV_NUM_BANKS],
    input  priv_csr_pkg::trap_info_t   trap_i,
    input  logic [1:0]                 trap_rtn_mode_i,
    output logic [`PRIV_XLEN-1:0]      rd_data_o,
    output logic                       bad_csr_addr_o,
    output logic                       readonly_csr_o,
    output logic                       priv_too_low_o,
    output logic [`PRIV_XLEN-1:0]      trap_entry_addr_o,
    output logic [`PRIV_XLEN-1:0]      trap_rtn_addr_o
);
    import priv_csr_pkg::*;

    bank_view_t            rd_bank;
    bank_view_t            tgt_bank;
    logic                  bank_addr;
    logic [`PRIV_XLEN-1:0] rd_data;
    logic                  rd_bad;
    logic [`PRIV_XLEN-1:0] tvec_base;

    // ----------------------------------------
    // read decode
    // ----------------------------------------
    assign rd_bank   = banks_i[(addr_i[9:8] == MODE_M) ? `PRIV_BANK_M : `PRIV_BANK_S];
    assign bank_addr = (addr_i[11:10] == 2'b00) &&
                       ((addr_i[9:8] == MODE_M) || (addr_i[9:8] == MODE_S));

    always_comb begin
        rd_data = '0;
        rd_bad  = 1'b0;
        case (addr_i)
            `PRIV_ADDR_SSTATUS:   rd_data = status_i.mstatus & `PRIV_SSTATUS_MASK;
            `PRIV_ADDR_SIE:       rd_data = {20'b0, status_i.mie & `PRIV_SIE_MASK};
            `PRIV_ADDR_MSTATUS:   rd_data = status_i.mstatus;
            `PRIV_ADDR_MEDELEG:   rd_data = {16'b0, status_i.medeleg};
            `PRIV_ADDR_MIDELEG:   rd_data = {16'b0, status_i.mideleg};
            `PRIV_ADDR_MIE:       rd_data = {20'b0, status_i.mie};
            `PRIV_ADDR_MVENDORID: rd_data = `PRIV_VENDOR_ID;
            `PRIV_ADDR_MARCHID:   rd_data = `PRIV_ARCH_ID;
            `PRIV_ADDR_MIMPID:    rd_data = `PRIV_IMPL_ID;
            `PRIV_ADDR_MHARTID:   rd_data = `PRIV_HART_ID;
            default: begin
                rd_bad = 1'b1;
                if (bank_addr) begin
                    rd_bad = 1'b0;
                    case (addr_i[7:0])
                        `PRIV_ADDR_TVEC_LO:    rd_data = rd_bank.tvec;
                        `PRIV_ADDR_SCRATCH_LO: rd_data = rd_bank.scratch;
                        `PRIV_ADDR_EPC_LO:     rd_data = rd_bank.epc;
                        `PRIV_ADDR_CAUSE_LO:   rd_data = rd_bank.cause;
                        `PRIV_ADDR_TVAL_LO:    rd_data = rd_bank.tval;
                        default:               rd_bad  = 1'b1;
                    endcase
                end
            end
        endcase
    end

    // data and flags hold between accesses
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            rd_data_o      <= '0;
            bad_csr_addr_o <= 1'b0;
            readonly_csr_o <= 1'b0;
            priv_too_low_o <= 1'b0;
        end else if (stage_en_i && access_i) begin
            rd_data_o      <= rd_data;
            bad_csr_addr_o <= rd_bad;
            readonly_csr_o <= (addr_i[11:10] == 2'b11);
            priv_too_low_o <= (addr_i[9:8] > status_i.mode);
        end
    end

    // ----------------------------------------
    // trap entry and return addresses
    // ----------------------------------------
    assign tgt_bank  = banks_i[(trap_i.target == MODE_M) ? `PRIV_BANK_M : `PRIV_BANK_S];
    assign tvec_base = {tgt_bank.tvec[`PRIV_XLEN-1:2], 2'b00};

    // vectored mode offsets interrupts by four times the cause number
    assign trap_entry_addr_o = (trap_i.irq && (tgt_bank.tvec[1:0] == 2'b01)) ?
                               tvec_base + {trap_i.cause[`PRIV_XLEN-3:0], 2'b00} : tvec_base;

    assign trap_rtn_addr_o =
        banks_i[(trap_rtn_mode_i == MODE_M) ? `PRIV_BANK_M : `PRIV_BANK_S].epc;

endmodule

//--- hw/priv_status.sv
// privilege mode and status registers
// mstatus, mie and delegation with trap entry and xret transitions
`timescale 1ns/1ps
`include "priv_csr_defs.svh"

module priv_status (
    input  logic                       clk_i,
    input  logic                       resetb_i,
    input  logic                       stage_en_i,
    input  priv_csr_pkg::csr_wr_t      wr_i,
    input  priv_csr_pkg::trap_info_t   trap_i,
    input  logic                       trap_rtn_i,
    input  logic [1:0]                 trap_rtn_mode_i,
    output priv_csr_pkg::status_view_t status_o,
    output priv_csr_pkg::priv_mode_e   mode_o
);
    import priv_csr_pkg::*;

    priv_mode_e            mode_q;
    logic [`PRIV_XLEN-1:0] mstatus_q;
    logic [11:0]           mie_q;
    logic [15:0]           medeleg_q;
    logic [15:0]           mideleg_q;
    logic [1:0]            mpp;

    assign mpp = mstatus_q[`PRIV_STATUS_MPP_HI:`PRIV_STATUS_MPP_LO];

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            mode_q    <= MODE_M;
            mstatus_q <= '0;
            mie_q     <= '0;
            medeleg_q <= '0;
            mideleg_q <= '0;
        end else if (stage_en_i) begin
            if (trap_i.take) begin
                if (trap_i.target == MODE_M) begin
                    mstatus_q[`PRIV_STATUS_MPP_HI:`PRIV_STATUS_MPP_LO] <= mode_q;
                    mstatus_q[`PRIV_STATUS_MPIE] <= mstatus_q[`PRIV_STATUS_MIE];
                    mstatus_q[`PRIV_STATUS_MIE]  <= 1'b0;
                end else begin
                    mstatus_q[`PRIV_STATUS_SPP]  <= (mode_q != MODE_U);
                    mstatus_q[`PRIV_STATUS_SPIE] <= mstatus_q[`PRIV_STATUS_SIE];
                    mstatus_q[`PRIV_STATUS_SIE]  <= 1'b0;
                end
                mode_q <= trap_i.target;
            end else if (trap_rtn_i) begin
                if (trap_rtn_mode_i == MODE_M) begin
                    // reserved MPP value falls back to U
                    mode_q <= (mpp == 2'b10) ? MODE_U : priv_mode_e'(mpp);
                    mstatus_q[`PRIV_STATUS_MIE]  <= mstatus_q[`PRIV_STATUS_MPIE];
                    mstatus_q[`PRIV_STATUS_MPIE] <= 1'b1;
                    mstatus_q[`PRIV_STATUS_MPP_HI:`PRIV_STATUS_MPP_LO] <= MODE_U;
                end else if (trap_rtn_mode_i == MODE_S) begin
                    mode_q <= mstatus_q[`PRIV_STATUS_SPP] ? MODE_S : MODE_U;
                    mstatus_q[`PRIV_STATUS_SIE]  <= mstatus_q[`PRIV_STATUS_SPIE];
                    mstatus_q[`PRIV_STATUS_SPIE] <= 1'b1;
                end
            end else if (wr_i.en) begin
                case (wr_i.addr)
                    // supervisor views touch only the S fields
                    `PRIV_ADDR_SSTATUS: begin
                        mstatus_q <= (wr_i.data & `PRIV_SSTATUS_MASK) |
                                     (mstatus_q & ~`PRIV_SSTATUS_MASK);
                    end
                    `PRIV_ADDR_SIE: begin
                        mie_q <= (wr_i.data[11:0] & `PRIV_SIE_MASK) | (mie_q & ~`PRIV_SIE_MASK);
                    end
                    `PRIV_ADDR_MSTATUS: mstatus_q <= wr_i.data & `PRIV_MSTATUS_MASK;
                    `PRIV_ADDR_MEDELEG: medeleg_q <= wr_i.data[15:0] & `PRIV_MEDELEG_MASK;
                    `PRIV_ADDR_MIDELEG: mideleg_q <= wr_i.data[15:0] & `PRIV_MIDELEG_MASK;
                    `PRIV_ADDR_MIE:     mie_q     <= wr_i.data[11:0] & `PRIV_MIE_MASK;
                    default: begin
                    end
                endcase
            end
        end
    end

    assign status_o.mode    = mode_q;
    assign status_o.mstatus = mstatus_q;
    assign status_o.mie     = mie_q;
    assign status_o.medeleg = medeleg_q;
    assign status_o.mideleg = mideleg_q;
    assign mode_o           = mode_q;

endmodule

//--- hw/trap_bank.sv
// trap register bank for one privilege level
// tvec, scratch, epc, cause and tval with CSR write and trap capture
`timescale 1ns/1ps
`include "priv_csr_defs.svh"

module trap_bank #(
    parameter priv_csr_pkg::priv_mode_e LEVEL = priv_csr_pkg::MODE_M
) (
    input  logic                     clk_i,
    input  logic                     resetb_i,
    input  logic                     stage_en_i,
    input  priv_csr_pkg::csr_wr_t    wr_i,
    input  priv_csr_pkg::trap_info_t trap_i,
    output priv_csr_pkg::bank_view_t view_o
);
    import priv_csr_pkg::*;

    localparam logic [`PRIV_XLEN-1:0] TVEC_RESET =
        (LEVEL == MODE_M) ? `PRIV_RESET_VECTOR : '0;

    bank_view_t bank_q;
    logic       wr_hit;
    logic       trap_hit;

    // read-write CSRs of this level only
    assign wr_hit   = wr_i.en && (wr_i.addr[11:10] == 2'b00) && (wr_i.addr[9:8] == LEVEL);
    assign trap_hit = trap_i.take && (trap_i.target == LEVEL);

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            bank_q.tvec    <= TVEC_RESET;
            bank_q.scratch <= '0;
            bank_q.epc     <= '0;
            bank_q.cause   <= '0;
            bank_q.tval    <= '0;
        end else if (stage_en_i) begin
            if (trap_i.take) begin
                // a trap to the other level blocks writes here as well
                if (trap_hit) begin
                    bank_q.epc   <= {trap_i.pc[`PRIV_XLEN-1:2], 2'b00};
                    bank_q.cause <= trap_i.cause;
                    bank_q.tval  <= trap_i.value;
                end
            end else if (wr_hit) begin
                case (wr_i.addr[7:0])
                    `PRIV_ADDR_TVEC_LO: begin
                        // mode 2 and 3 are reserved
                        bank_q.tvec <= {wr_i.data[`PRIV_XLEN-1:2], 1'b0, wr_i.data[0]};
                    end
                    `PRIV_ADDR_SCRATCH_LO: begin
                        bank_q.scratch <= wr_i.data;
                    end
                    `PRIV_ADDR_EPC_LO: begin
                        bank_q.epc <= {wr_i.data[`PRIV_XLEN-1:2], 2'b00};
                    end
                    `PRIV_ADDR_CAUSE_LO: begin
                        bank_q.cause <= wr_i.data;
                    end
                    `PRIV_ADDR_TVAL_LO: begin
                        bank_q.tval <= wr_i.data;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign view_o = bank_q;

endmodule

//--- hw/trap_cause_unit.sv
// trap cause unit
// pending interrupt detect, cause and value encoding, delegation target
`timescale 1ns/1ps
`include "priv_csr_defs.svh"

module trap_cause_unit (
    input  priv_csr_pkg::status_view_t status_i,
    input  logic                       ex_valid_i,
    input  logic                       irq_m_ext_i,
    input  logic                       irq_m_sw_i,
    input  logic                       irq_m_tmr_i,
    input  logic                       irq_s_ext_i,
    input  logic                       irq_s_sw_i,
    input  logic                       irq_s_tmr_i,
    input  logic                       excp_ferr_i,
    input  logic                       excp_ilgl_i,
    input  logic                       excp_mala_i,
    input  logic                       excp_masa_i,
    input  logic                       excp_ecall_i,
    input  logic [`PRIV_XLEN-1:0]      excp_pc_i,
    input  logic [`PRIV_XLEN-1:0]      excp_ins_i,
    output priv_csr_pkg::trap_info_t   trap_o,
    output logic                       interrupt_o
);
    import priv_csr_pkg::*;

    logic [11:0]           raw_irq;
    logic [11:0]           irq_mask;
    logic [11:0]           irq_v;
    logic                  m_glb_en;
    logic                  s_glb_en;
    logic                  excp_any;
    logic [`PRIV_XLEN-1:0] icause;
    logic [`PRIV_XLEN-1:0] ecause;
    logic [`PRIV_XLEN-1:0] evalue;
    logic [`PRIV_XLEN-1:0] cause;
    logic [3:0]            deleg_idx;
    logic                  deleg;

    // ----------------------------------------
    // interrupt pending
    // ----------------------------------------
    assign raw_irq = {irq_m_ext_i, 1'b0, irq_s_ext_i, 1'b0,
                      irq_m_tmr_i, 1'b0, irq_s_tmr_i, 1'b0,
                      irq_m_sw_i,  1'b0, irq_s_sw_i,  1'b0};

    assign m_glb_en = status_i.mstatus[`PRIV_STATUS_MIE] || (status_i.mode != MODE_M);
    assign s_glb_en = (status_i.mode == MODE_U) ||
                      ((status_i.mode == MODE_S) && status_i.mstatus[`PRIV_STATUS_SIE]);

    assign irq_mask    = {3{m_glb_en, 1'b0, s_glb_en, 1'b0}};
    assign irq_v       = raw_irq & status_i.mie & irq_mask;
    assign interrupt_o = |irq_v;

    // external, then software, then timer
    always_comb begin
        if (irq_v[11])     icause = CAUSE_INTR_ME;
        else if (irq_v[9]) icause = CAUSE_INTR_SE;
        else if (irq_v[3]) icause = CAUSE_INTR_MS;
        else if (irq_v[1]) icause = CAUSE_INTR_SS;
        else if (irq_v[7]) icause = CAUSE_INTR_MT;
        else               icause = CAUSE_INTR_ST;
    end

    // ----------------------------------------
    // exception cause and trap value
    // ----------------------------------------
    always_comb begin
        ecause = '0;
        evalue = '0;
        if (excp_ferr_i) begin
            ecause = CAUSE_EXCP_INS_FAULT;
        end else if (excp_ilgl_i) begin
            ecause = CAUSE_EXCP_ILLEGAL;
            evalue = excp_ins_i;
        end else if (excp_mala_i) begin
            ecause = CAUSE_EXCP_LOAD_MALA;
            evalue = excp_pc_i;
        end else if (excp_masa_i) begin
            ecause = CAUSE_EXCP_STORE_MALA;
            evalue = excp_pc_i;
        end else begin
            case (status_i.mode)
                MODE_M:  ecause = CAUSE_EXCP_ECALL_M;
                MODE_S:  ecause = CAUSE_EXCP_ECALL_S;
                default: ecause = CAUSE_EXCP_ECALL_U;
            endcase
        end
    end

    assign excp_any = excp_ferr_i | excp_ilgl_i | excp_mala_i | excp_masa_i | excp_ecall_i;
    assign cause    = interrupt_o ? icause : ecause;

    // delegation to S only from below M
    assign deleg_idx = cause[3:0];
    assign deleg     = (status_i.mode != MODE_M) &&
                       (interrupt_o ? status_i.mideleg[deleg_idx] : status_i.medeleg[deleg_idx]);

    assign trap_o.take   = ex_valid_i & (interrupt_o | excp_any);
    assign trap_o.irq    = interrupt_o;
    assign trap_o.target = deleg ? MODE_S : MODE_M;
    assign trap_o.cause  = cause;
    assign trap_o.value  = interrupt_o ? '0 : evalue;
    assign trap_o.pc     = excp_pc_i;

endmodule

//--- hw/priv_csr_pkg.sv
// privileged CSR types
// mode encoding, trap cause codes and the structs passed between units
`include "priv_csr_defs.svh"

package priv_csr_pkg;

    typedef enum logic [1:0] {
        MODE_U = 2'd0,
        MODE_S = 2'd1,
        MODE_M = 2'd3
    } priv_mode_e;

    // interrupt causes carry bit 31
    localparam logic [`PRIV_XLEN-1:0] CAUSE_INTR_SS = 32'h8000_0001;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_INTR_MS = 32'h8000_0003;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_INTR_ST = 32'h8000_0005;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_INTR_MT = 32'h8000_0007;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_INTR_SE = 32'h8000_0009;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_INTR_ME = 32'h8000_000B;

    localparam logic [`PRIV_XLEN-1:0] CAUSE_EXCP_INS_FAULT  = 32'd1;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_EXCP_ILLEGAL    = 32'd2;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_EXCP_LOAD_MALA  = 32'd4;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_EXCP_STORE_MALA = 32'd6;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_EXCP_ECALL_U    = 32'd8;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_EXCP_ECALL_S    = 32'd9;
    localparam logic [`PRIV_XLEN-1:0] CAUSE_EXCP_ECALL_M    = 32'd11;

    typedef struct packed {
        logic                  en;
        logic [11:0]           addr;
        logic [`PRIV_XLEN-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic                  take;
        logic                  irq;
        priv_mode_e            target;
        logic [`PRIV_XLEN-1:0] cause;
        logic [`PRIV_XLEN-1:0] value;
        logic [`PRIV_XLEN-1:0] pc;
    } trap_info_t;

    typedef struct packed {
        logic [`PRIV_XLEN-1:0] tvec;
        logic [`PRIV_XLEN-1:0] scratch;
        logic [`PRIV_XLEN-1:0] epc;
        logic [`PRIV_XLEN-1:0] cause;
        logic [`PRIV_XLEN-1:0] tval;
    } bank_view_t;

    typedef struct packed {
        priv_mode_e            mode;
        logic [`PRIV_XLEN-1:0] mstatus;
        logic [11:0]           mie;
        logic [15:0]           medeleg;
        logic [15:0]           mideleg;
    } status_view_t;

endpackage

//--- hw/priv_csr_defs.svh
// privileged CSR block constants
// data width, reset vector, ID values, CSR addresses and field positions
`ifndef PRIV_CSR_DEFS_SVH
`define PRIV_CSR_DEFS_SVH

`define PRIV_XLEN           32
`define PRIV_RESET_VECTOR   32'h0000_0100
`define PRIV_NUM_BANKS      2
`define PRIV_BANK_M         0
`define PRIV_BANK_S         1

`define PRIV_VENDOR_ID      32'h0000_0000
`define PRIV_ARCH_ID        32'h0000_0000
`define PRIV_IMPL_ID        32'h0000_0001
`define PRIV_HART_ID        32'h0000_0000

// status, enable and delegation registers
`define PRIV_ADDR_SSTATUS   12'h100
`define PRIV_ADDR_SIE       12'h104
`define PRIV_ADDR_MSTATUS   12'h300
`define PRIV_ADDR_MEDELEG   12'h302
`define PRIV_ADDR_MIDELEG   12'h303
`define PRIV_ADDR_MIE       12'h304
`define PRIV_ADDR_MVENDORID 12'hF11
`define PRIV_ADDR_MARCHID   12'hF12
`define PRIV_ADDR_MIMPID    12'hF13
`define PRIV_ADDR_MHARTID   12'hF14

// bank registers, level goes in bits 9:8
`define PRIV_ADDR_TVEC_LO    8'h05
`define PRIV_ADDR_SCRATCH_LO 8'h40
`define PRIV_ADDR_EPC_LO     8'h41
`define PRIV_ADDR_CAUSE_LO   8'h42
`define PRIV_ADDR_TVAL_LO    8'h43

// mstatus bit positions
`define PRIV_STATUS_SIE     1
`define PRIV_STATUS_MIE     3
`define PRIV_STATUS_SPIE    5
`define PRIV_STATUS_MPIE    7
`define PRIV_STATUS_SPP     8
`define PRIV_STATUS_MPP_LO  11
`define PRIV_STATUS_MPP_HI  12

// writable field masks
`define PRIV_MSTATUS_MASK   32'h0000_19AA
`define PRIV_SSTATUS_MASK   32'h0000_0122
`define PRIV_MIE_MASK       12'hAAA
`define PRIV_SIE_MASK       12'h222
`define PRIV_MEDELEG_MASK   16'h0356
`define PRIV_MIDELEG_MASK   16'h0222

`endif
